/* compile.f */
+incdir+src
src/ctrl_pkg.sv
src/cmd_decode.sv
src/ctrl_exec.sv
src/resp_build.sv
src/ctrl_core.sv
verification/tb_ctrl_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ctrl_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_ctrl_core \
  --Mdir obj_dir -o sim_ctrl_core

# a $fatal gives a nonzero exit, so the log is searched instead
./obj_dir/sim_ctrl_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi

exit 0

/* src/cmd_decode.sv */
/*
  Command capture and address decode.
  cmd_cnt_i toggles once per command and may come from another clock.
  Address, data and response request must be stable from a cycle before
  the toggle until the next one; toggles at least two cycles apart.
  Hold cmd_cnt_i at 0 during reset, or a false command is seen.
*/

`include "ctrl_defines.svh"

module cmd_decode (
  input  logic                    clk_ctrl,
  input  logic                    rst_n_i,
  input  logic                    cmd_cnt_i,
  input  logic [`CTRL_ADDR_W-1:0] cmd_addr_i,
  input  logic [`CTRL_DATA_W-1:0] cmd_data_i,
  input  logic                    cmd_resprqst_i,
  output logic                    dec_valid_o,
  output ctrl_pkg::cmd_kind_e     dec_kind_o,
  output logic [`CTRL_ADDR_W-1:0] dec_addr_o,
  output ctrl_pkg::cmd_word_u     dec_word_o,
  output logic                    dec_resprqst_o
);
  import ctrl_pkg::*;

  localparam int cap_w = 1 + `CTRL_ADDR_W + `CTRL_DATA_W;

  logic                    cnt_meta;
  logic                    cnt_sync;
  logic                    cnt_prev;
  logic                    new_cmd;
  logic [cap_w-1:0]        cap_d1;
  logic [cap_w-1:0]        cap_d2;
  logic [`CTRL_ADDR_W-1:0] cap_addr;
  cmd_kind_e               cap_kind;

  ////////////////////////////////////////
  // toggle synchronizer and edge detect

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      cnt_meta    <= 1'b0;
      cnt_sync    <= 1'b0;
      cnt_prev    <= 1'b0;
      dec_valid_o <= 1'b0;
    end else begin
      cnt_meta    <= cmd_cnt_i;
      cnt_sync    <= cnt_meta;
      cnt_prev    <= cnt_sync;
      dec_valid_o <= new_cmd;
    end
  end

  assign new_cmd = cnt_sync ^ cnt_prev;

  // payload delayed alongside the synchronizer so a following
  // command cannot overwrite it before capture
  always_ff @(posedge clk_ctrl) begin
    cap_d1 <= {cmd_resprqst_i, cmd_addr_i, cmd_data_i};
    cap_d2 <= cap_d1;
  end

  assign cap_addr = cap_d2[`CTRL_DATA_W +: `CTRL_ADDR_W];

  always_comb begin
    case (cap_addr)
      `CTRL_ADDR_GENERAL: cap_kind = KIND_GENERAL;
      `CTRL_ADDR_NETCFG:  cap_kind = KIND_NETCFG;
      default:            cap_kind = KIND_OTHER;
    endcase
  end

  always_ff @(posedge clk_ctrl) begin
    if (new_cmd) begin
      dec_kind_o     <= cap_kind;
      dec_addr_o     <= cap_addr;
      dec_word_o     <= cap_d2[`CTRL_DATA_W-1:0];
      dec_resprqst_o <= cap_d2[cap_w-1];
    end
  end

endmodule

/* src/ctrl_core.sv */
/*
  Control-domain command path, all on clk_ctrl.
  Settings change 4 edges after the toggle is first sampled and the
  response appears 5 edges after; up to three commands in flight.
*/

`include "ctrl_defines.svh"

module ctrl_core (
  input  logic                    clk_ctrl,
  input  logic                    rst_n_i,
  input  logic                    cmd_cnt_i,
  input  logic [`CTRL_ADDR_W-1:0] cmd_addr_i,
  input  logic [`CTRL_DATA_W-1:0] cmd_data_i,
  input  logic                    cmd_resprqst_i,
  input  logic                    tx_inhibit_i,
  input  logic                    alternate_mac_i,
  output logic                    run_o,
  output logic                    wide_spectrum_o,
  output logic                    tx_on_o,
  output logic [7:0]              eeprom_config_o,
  output logic [`CTRL_MAC_W-1:0]  local_mac_o,
  output logic [`CTRL_RESP_W-1:0] resp_o,
  output logic                    resp_valid_o
);

  // decode to execute
  logic                    dec_valid;
  ctrl_pkg::cmd_kind_e     dec_kind;
  logic [`CTRL_ADDR_W-1:0] dec_addr;
  ctrl_pkg::cmd_word_u     dec_word;
  logic                    dec_resprqst;

  // execute to response
  logic                    exec_done;
  ctrl_pkg::cmd_kind_e     exec_kind;
  logic [`CTRL_ADDR_W-1:0] exec_addr;
  logic                    exec_resprqst;
  logic [`CTRL_DATA_W-1:0] exec_rdata;

  cmd_decode cmd_decode_i (
    .clk_ctrl       (clk_ctrl),
    .rst_n_i        (rst_n_i),
    .cmd_cnt_i      (cmd_cnt_i),
    .cmd_addr_i     (cmd_addr_i),
    .cmd_data_i     (cmd_data_i),
    .cmd_resprqst_i (cmd_resprqst_i),
    .dec_valid_o    (dec_valid),
    .dec_kind_o     (dec_kind),
    .dec_addr_o     (dec_addr),
    .dec_word_o     (dec_word),
    .dec_resprqst_o (dec_resprqst)
  );

  ctrl_exec ctrl_exec_i (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .dec_valid_i     (dec_valid),
    .dec_kind_i      (dec_kind),
    .dec_addr_i      (dec_addr),
    .dec_word_i      (dec_word),
    .dec_resprqst_i  (dec_resprqst),
    .tx_inhibit_i    (tx_inhibit_i),
    .alternate_mac_i (alternate_mac_i),
    .run_o           (run_o),
    .wide_spectrum_o (wide_spectrum_o),
    .tx_on_o         (tx_on_o),
    .eeprom_config_o (eeprom_config_o),
    .alt_mac_o       (),
    .local_mac_o     (local_mac_o),
    .exec_done_o     (exec_done),
    .exec_kind_o     (exec_kind),
    .exec_addr_o     (exec_addr),
    .exec_resprqst_o (exec_resprqst),
    .exec_rdata_o    (exec_rdata)
  );

  resp_build resp_build_i (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .exec_done_i     (exec_done),
    .exec_kind_i     (exec_kind),
    .exec_addr_i     (exec_addr),
    .exec_resprqst_i (exec_resprqst),
    .exec_rdata_i    (exec_rdata),
    .run_i           (run_o),
    .tx_on_i         (tx_on_o),
    .resp_o          (resp_o),
    .resp_valid_o    (resp_valid_o)
  );

endmodule

/* src/ctrl_defines.svh */
/*
  Widths, command addresses and fixed identity values of the control path.
  Eight-bit EEPROM configuration and 16-bit MAC tail are fixed by the
  word layout in ctrl_pkg and do not follow these macros.
*/

`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// bus widths
`define CTRL_ADDR_W 6
`define CTRL_DATA_W 32
`define CTRL_RESP_W 40
`define CTRL_MAC_W 48

////////////////////////////////////////
// command addresses

// run, wide spectrum and tx request flags
`define CTRL_ADDR_GENERAL 6'h00
// eeprom config byte and alternate mac tail
`define CTRL_ADDR_NETCFG 6'h39

////////////////////////////////////////
// identity

`define CTRL_BASE_MAC 48'h001cc0a213dd
// echoed in the low byte of a netcfg readback
`define CTRL_VERSION_MINOR 8'd4
// eeprom config bit that swaps in the alternate mac tail
`define CTRL_ALTMAC_SEL_BIT 6

`endif

/* src/ctrl_exec.sv */
/*
  Control registers, transmit gating and local MAC.
  Registers update one cycle after dec_valid_i; addresses other than the
  general and netcfg words leave all state alone.
  tx_on_o and local_mac_o are combinational from the registers and the
  tx_inhibit_i and alternate_mac_i levels.
*/

`include "ctrl_defines.svh"

module ctrl_exec (
  input  logic                    clk_ctrl,
  input  logic                    rst_n_i,
  input  logic                    dec_valid_i,
  input  ctrl_pkg::cmd_kind_e     dec_kind_i,
  input  logic [`CTRL_ADDR_W-1:0] dec_addr_i,
  input  ctrl_pkg::cmd_word_u     dec_word_i,
  input  logic                    dec_resprqst_i,
  input  logic                    tx_inhibit_i,
  input  logic                    alternate_mac_i,
  output logic                    run_o,
  output logic                    wide_spectrum_o,
  output logic                    tx_on_o,
  output logic [7:0]              eeprom_config_o,
  output logic [15:0]             alt_mac_o,
  output logic [`CTRL_MAC_W-1:0]  local_mac_o,
  output logic                    exec_done_o,
  output ctrl_pkg::cmd_kind_e     exec_kind_o,
  output logic [`CTRL_ADDR_W-1:0] exec_addr_o,
  output logic                    exec_resprqst_o,
  output logic [`CTRL_DATA_W-1:0] exec_rdata_o
);
  import ctrl_pkg::*;

  localparam logic [`CTRL_MAC_W-1:0] base_mac = `CTRL_BASE_MAC;

  logic                    tx_req_q;
  logic                    run_d;
  logic                    wide_d;
  logic                    tx_req_d;
  logic [7:0]              eeprom_d;
  logic [15:0]             alt_mac_d;
  logic [`CTRL_DATA_W-1:0] rdata_d;

  always_comb begin
    run_d     = run_o;
    wide_d    = wide_spectrum_o;
    tx_req_d  = tx_req_q;
    eeprom_d  = eeprom_config_o;
    alt_mac_d = alt_mac_o;
    if (dec_valid_i) begin
      case (dec_kind_i)
        KIND_GENERAL: begin
          run_d    = dec_word_i.general.run;
          wide_d   = dec_word_i.general.wide_spectrum;
          tx_req_d = dec_word_i.general.tx_req;
        end
        KIND_NETCFG: begin
          eeprom_d  = dec_word_i.netcfg.eeprom_config;
          alt_mac_d = dec_word_i.netcfg.alt_mac;
        end
        default: ;
      endcase
    end
    // readback reflects the values being written this cycle
    case (dec_kind_i)
      KIND_GENERAL: rdata_d = {{(`CTRL_DATA_W-3){1'b0}}, tx_req_d, wide_d, run_d};
      KIND_NETCFG:  rdata_d = {eeprom_d, alt_mac_d, `CTRL_VERSION_MINOR};
      default:      rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      run_o           <= 1'b0;
      wide_spectrum_o <= 1'b0;
      tx_req_q        <= 1'b0;
      eeprom_config_o <= 8'h00;
      alt_mac_o       <= 16'h0000;
      exec_done_o     <= 1'b0;
    end else begin
      run_o           <= run_d;
      wide_spectrum_o <= wide_d;
      tx_req_q        <= tx_req_d;
      eeprom_config_o <= eeprom_d;
      alt_mac_o       <= alt_mac_d;
      exec_done_o     <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (dec_valid_i) begin
      exec_kind_o     <= dec_kind_i;
      exec_addr_o     <= dec_addr_i;
      exec_resprqst_o <= dec_resprqst_i;
      exec_rdata_o    <= rdata_d;
    end
  end

  assign tx_on_o = tx_req_q & ~tx_inhibit_i;

  // alternate tail from eeprom, else jumper flips bit 1 of the base mac
  assign local_mac_o = eeprom_config_o[`CTRL_ALTMAC_SEL_BIT] ?
                       {base_mac[`CTRL_MAC_W-1:16], alt_mac_o} :
                       {base_mac[`CTRL_MAC_W-1:2], ~alternate_mac_i, base_mac[0]};

endmodule

/* src/ctrl_pkg.sv */
/*
  Types shared by the control path.
  A command data word has no fixed meaning of its own: the address decides
  whether it is read as a general word or as a netcfg word.
*/

`include "ctrl_defines.svh"

package ctrl_pkg;

  // result of address decode, computed once in cmd_decode
  typedef enum logic [1:0] {
    KIND_GENERAL,
    KIND_NETCFG,
    KIND_OTHER
  } cmd_kind_e;

  // general control word, address 0x00
  typedef struct packed {
    logic [`CTRL_DATA_W-4:0] rsvd;
    logic                    tx_req;
    logic                    wide_spectrum;
    logic                    run;
  } general_word_t;

  // network configuration word, address 0x39
  typedef struct packed {
    logic [7:0]  eeprom_config;
    logic [15:0] alt_mac;
    logic [7:0]  rsvd;
  } netcfg_word_t;

  // one data word, two readings
  typedef union packed {
    general_word_t general;
    netcfg_word_t  netcfg;
  } cmd_word_u;

endpackage

/* src/resp_build.sv */
/*
  Response word for commands that ask for one.
  Layout from the top: address, tx on, run, 32-bit readback.
  No back-pressure; a new response simply replaces resp_o.
*/

`include "ctrl_defines.svh"

module resp_build (
  input  logic                    clk_ctrl,
  input  logic                    rst_n_i,
  input  logic                    exec_done_i,
  input  ctrl_pkg::cmd_kind_e     exec_kind_i,
  input  logic [`CTRL_ADDR_W-1:0] exec_addr_i,
  input  logic                    exec_resprqst_i,
  input  logic [`CTRL_DATA_W-1:0] exec_rdata_i,
  input  logic                    run_i,
  input  logic                    tx_on_i,
  output logic [`CTRL_RESP_W-1:0] resp_o,
  output logic                    resp_valid_o
);
  import ctrl_pkg::*;

  logic resp_load;

  assign resp_load = exec_done_i & exec_resprqst_i;

  ////////////////////////////////////////
  // response register

  // unknown addresses arrive with a zero readback from ctrl_exec
  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      resp_o       <= '0;
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= resp_load;
      if (resp_load) begin
        resp_o <= {exec_addr_i, tx_on_i, run_i, exec_rdata_i};
      end
    end
  end

endmodule

/* verification/tb_ctrl_core.sv */
/*
  Testbench for ctrl_core.
  Inputs change 1 time unit after the rising edge, outputs are sampled there.
  Table commands get 5 edges each; a short burst at the end issues
  commands 2 cycles apart and checks that responses arrive in order.
*/

`include "ctrl_defines.svh"

module tb_ctrl_core;
  import ctrl_pkg::*;

  localparam int clk_period = 8;
  localparam int tbl_len    = 12;
  localparam int burst_len  = 3;

  typedef struct packed {
    logic [`CTRL_ADDR_W-1:0] addr;
    logic [`CTRL_DATA_W-1:0] data;
    logic                    rqst;
    logic                    inhibit;
    logic                    alt_in;
    logic                    exp_run;
    logic                    exp_wide;
    logic                    exp_tx_on;
    logic [7:0]              exp_eeprom;
  } entry_t;

  logic                    clk_ctrl;
  logic                    rst_n_i;
  logic                    cmd_cnt_i;
  logic [`CTRL_ADDR_W-1:0] cmd_addr_i;
  logic [`CTRL_DATA_W-1:0] cmd_data_i;
  logic                    cmd_resprqst_i;
  logic                    tx_inhibit_i;
  logic                    alternate_mac_i;
  logic                    run_o;
  logic                    wide_spectrum_o;
  logic                    tx_on_o;
  logic [7:0]              eeprom_config_o;
  logic [`CTRL_MAC_W-1:0]  local_mac_o;
  logic [`CTRL_RESP_W-1:0] resp_o;
  logic                    resp_valid_o;

  entry_t                  tbl [tbl_len];
  logic [`CTRL_ADDR_W-1:0] burst_addr [burst_len];
  logic [`CTRL_DATA_W-1:0] burst_data [burst_len];

  // reference model of the control registers
  logic                    m_run;
  logic                    m_wide;
  logic                    m_tx_req;
  logic [7:0]              m_eeprom;
  logic [15:0]             m_alt_mac;
  logic [`CTRL_RESP_W-1:0] last_resp;
  logic [`CTRL_RESP_W-1:0] exp_q [$];

  ctrl_core dut_i (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .cmd_cnt_i       (cmd_cnt_i),
    .cmd_addr_i      (cmd_addr_i),
    .cmd_data_i      (cmd_data_i),
    .cmd_resprqst_i  (cmd_resprqst_i),
    .tx_inhibit_i    (tx_inhibit_i),
    .alternate_mac_i (alternate_mac_i),
    .run_o           (run_o),
    .wide_spectrum_o (wide_spectrum_o),
    .tx_on_o         (tx_on_o),
    .eeprom_config_o (eeprom_config_o),
    .local_mac_o     (local_mac_o),
    .resp_o          (resp_o),
    .resp_valid_o    (resp_valid_o)
  );

  always #(clk_period / 2) clk_ctrl = ~clk_ctrl;

  ////////////////////////////////////////
  // reporting and compare tasks

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_mac(input string name, input logic [`CTRL_MAC_W-1:0] got,
                           input logic [`CTRL_MAC_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input logic [`CTRL_RESP_W-1:0] got,
                            input logic [`CTRL_RESP_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_ctrl);
    #1;
  endtask

  ////////////////////////////////////////
  // reference model

  task automatic model_apply(input logic [`CTRL_ADDR_W-1:0] addr,
                             input logic [`CTRL_DATA_W-1:0] data);
    cmd_word_u w;
    w = data;
    if (addr == `CTRL_ADDR_GENERAL) begin
      m_run    = w.general.run;
      m_wide   = w.general.wide_spectrum;
      m_tx_req = w.general.tx_req;
    end else if (addr == `CTRL_ADDR_NETCFG) begin
      m_eeprom  = w.netcfg.eeprom_config;
      m_alt_mac = w.netcfg.alt_mac;
    end
  endtask

  function automatic logic [`CTRL_MAC_W-1:0] model_mac(input logic alt_in);
    logic [`CTRL_MAC_W-1:0] mac;
    mac = `CTRL_BASE_MAC;
    if (m_eeprom[`CTRL_ALTMAC_SEL_BIT]) begin
      mac[15:0] = m_alt_mac;
    end else begin
      mac[1] = ~alt_in;
    end
    return mac;
  endfunction

  // address, tx on, run, then readback of the registers after the update
  function automatic logic [`CTRL_RESP_W-1:0] model_resp(input logic [`CTRL_ADDR_W-1:0] addr,
                                                         input logic inhibit);
    logic [`CTRL_DATA_W-1:0] rdata;
    rdata = '0;
    if (addr == `CTRL_ADDR_GENERAL) begin
      rdata[0] = m_run;
      rdata[1] = m_wide;
      rdata[2] = m_tx_req;
    end else if (addr == `CTRL_ADDR_NETCFG) begin
      rdata = {m_eeprom, m_alt_mac, `CTRL_VERSION_MINOR};
    end
    return {addr, m_tx_req & ~inhibit, m_run, rdata};
  endfunction

  initial begin
    #((tbl_len * 10 + 20) * clk_period);
    abort_run("timeout: the test sequence did not finish in time");
  end

  initial begin
    // addr, data, rqst, inhibit, alt_in, run, wide, tx_on, eeprom
    tbl[0]  = '{6'h00, 32'h0000_0007, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 8'h00};
    tbl[1]  = '{6'h00, 32'h0000_0007, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 8'h00};
    tbl[2]  = '{6'h00, 32'h0000_0005, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 8'h00};
    tbl[3]  = '{6'h39, 32'h40BE_EF00, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 8'h40};
    tbl[4]  = '{6'h39, 32'h0012_3400, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 8'h00};
    tbl[5]  = '{6'h39, 32'h2A56_78FF, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 8'h2A};
    tbl[6]  = '{6'h12, 32'hFFFF_FFFF, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 8'h2A};
    tbl[7]  = '{6'h3F, 32'h0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 8'h2A};
    tbl[8]  = '{6'h00, 32'hFFFF_FFF8, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h2A};
    tbl[9]  = '{6'h39, 32'hC000_0000, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'hC0};
    tbl[10] = '{6'h00, 32'h0000_0002, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 8'hC0};
    tbl[11] = '{6'h00, 32'h0000_0006, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 8'hC0};
    burst_addr[0] = 6'h00;
    burst_data[0] = 32'h0000_0003;
    burst_addr[1] = 6'h39;
    burst_data[1] = 32'h41AB_CD00;
    burst_addr[2] = 6'h05;
    burst_data[2] = 32'hDEAD_BEEF;

    clk_ctrl        = 1'b0;
    rst_n_i         = 1'b0;
    cmd_cnt_i       = 1'b0;
    cmd_addr_i      = '0;
    cmd_data_i      = '0;
    cmd_resprqst_i  = 1'b0;
    tx_inhibit_i    = 1'b0;
    alternate_mac_i = 1'b0;
    m_run     = 1'b0;
    m_wide    = 1'b0;
    m_tx_req  = 1'b0;
    m_eeprom  = 8'h00;
    m_alt_mac = 16'h0000;
    last_resp = '0;

    repeat (2) next_cycle();
    rst_n_i = 1'b1;
    next_cycle();

    // state straight after reset
    check_flag("run_o", run_o, 1'b0);
    check_flag("wide_spectrum_o", wide_spectrum_o, 1'b0);
    check_flag("tx_on_o", tx_on_o, 1'b0);
    check_flag("resp_valid_o", resp_valid_o, 1'b0);
    check_byte("eeprom_config_o", eeprom_config_o, 8'h00);
    check_mac("local_mac_o", local_mac_o, model_mac(1'b0));
    check_resp("resp_o", resp_o, '0);

    ////////////////////////////////////////
    // table commands, one at a time

    for (int i = 0; i < tbl_len; i++) begin
      next_cycle();
      check_flag("resp_valid_o", resp_valid_o, 1'b0);
      cmd_addr_i      = tbl[i].addr;
      cmd_data_i      = tbl[i].data;
      cmd_resprqst_i  = tbl[i].rqst;
      tx_inhibit_i    = tbl[i].inhibit;
      alternate_mac_i = tbl[i].alt_in;
      model_apply(tbl[i].addr, tbl[i].data);
      next_cycle();
      check_flag("resp_valid_o", resp_valid_o, 1'b0);
      cmd_cnt_i = ~cmd_cnt_i;
      for (int e = 1; e < 5; e++) begin
        next_cycle();
        check_flag("resp_valid_o", resp_valid_o, 1'b0);
      end
      next_cycle();
      if (tbl[i].rqst) begin
        last_resp = model_resp(tbl[i].addr, tbl[i].inhibit);
      end
      check_flag("resp_valid_o", resp_valid_o, tbl[i].rqst);
      check_flag("run_o", run_o, tbl[i].exp_run);
      check_flag("wide_spectrum_o", wide_spectrum_o, tbl[i].exp_wide);
      check_flag("tx_on_o", tx_on_o, tbl[i].exp_tx_on);
      check_byte("eeprom_config_o", eeprom_config_o, tbl[i].exp_eeprom);
      check_mac("local_mac_o", local_mac_o, model_mac(tbl[i].alt_in));
      check_resp("resp_o", resp_o, last_resp);
    end
    next_cycle();
    check_flag("resp_valid_o", resp_valid_o, 1'b0);

    ////////////////////////////////////////
    // burst, commands 2 cycles apart

    tx_inhibit_i    = 1'b0;
    alternate_mac_i = 1'b0;
    cmd_resprqst_i  = 1'b1;
    for (int c = 0; c < 2 * burst_len + 8; c++) begin
      next_cycle();
      if (resp_valid_o) begin
        if (exp_q.size() == 0) begin
          abort_run("response pulse seen with no response outstanding");
        end else begin
          last_resp = exp_q.pop_front();
          check_resp("resp_o", resp_o, last_resp);
        end
      end
      if (c < 2 * burst_len && c % 2 == 0) begin
        cmd_addr_i = burst_addr[c / 2];
        cmd_data_i = burst_data[c / 2];
        model_apply(burst_addr[c / 2], burst_data[c / 2]);
        exp_q.push_back(model_resp(burst_addr[c / 2], 1'b0));
      end else if (c < 2 * burst_len) begin
        cmd_cnt_i = ~cmd_cnt_i;
      end
    end
    if (exp_q.size() != 0) begin
      abort_run("a burst command never produced its response");
    end
    check_flag("run_o", run_o, m_run);
    check_flag("wide_spectrum_o", wide_spectrum_o, m_wide);
    check_flag("tx_on_o", tx_on_o, m_tx_req);
    check_byte("eeprom_config_o", eeprom_config_o, m_eeprom);
    check_mac("local_mac_o", local_mac_o, model_mac(1'b0));

    $display("Result: PASSED");
    $finish;
  end

endmodule
